// File: isaPkg.sv
// Instruction set definitions for the 18-bit stack CPU. Bits 17 and 16 of an instruction are ignored.
package isaPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes in instruction bits 15 to 12
  typedef enum logic [3:0] {
    opHalt  = 4'b0000,  // No-op, the core never stops
    opPushi = 4'b0001,
    opPush  = 4'b0010,
    opPop   = 4'b0011,
    opJmp   = 4'b0100,
    opJz    = 4'b0101,
    opJnz   = 4'b0110,
    opLd    = 4'b0111,
    opSt    = 4'b1000,
    opPppc  = 4'b1001,  // Bit 0 picks PUSHPC or POPPC
    opIn    = 4'b1101,
    opOut   = 4'b1110,
    opOp    = 4'b1111
  } opcodeT;

  // ALU function codes in bits 4 to 0 of an OP
  typedef enum logic [4:0] {
    funcAdd  = 5'b00000, funcSub = 5'b00001, funcMul  = 5'b00010, funcShl = 5'b00011,
    funcShr  = 5'b00100, funcBand = 5'b00101, funcBor = 5'b00110, funcBxor = 5'b00111,
    funcAnd  = 5'b01000, funcOr  = 5'b01001, funcEq   = 5'b01010, funcNe  = 5'b01011,
    funcGe   = 5'b01100, funcLe  = 5'b01101, funcGt   = 5'b01110, funcLt  = 5'b01111,
    funcNeg  = 5'b10000, funcBnot = 5'b10001, funcNot = 5'b10010,
    funcA    = 5'b10011,  // Dup
    funcB    = 5'b10111,  // Drop
    funcAa   = 5'b11011,  // Dropnext
    funcBa   = 5'b11111   // Over
  } aluFuncT;

  typedef logic [2:0] portSelT;  // Eight port numbers, four are wired

  // Instruction field positions
  localparam int OpcodeHi = 15;
  localparam int OpcodeLo = 12;
  localparam int ImmHi    = 11;  // Immediate or RAM address
  localparam int ImmLo    = 0;
  localparam int FuncHi   = 4;
  localparam int FuncLo   = 0;
  localparam int PortHi   = 2;
  localparam int PortLo   = 0;

endpackage

// File: corePkg.sv
// Machine organisation of the core. Widths are fixed at 18-bit words and 12-bit addresses.
package corePkg;

  typedef logic [17:0] wordT;  // Data word, stack entry and instruction
  typedef logic [11:0] addrT;  // RAM and PC address

  // Sequencer states
  typedef enum logic [2:0] {
    idle   = 3'b000,
    fetchA = 3'b001,
    fetchB = 3'b010,
    execA  = 3'b011,
    execB  = 3'b100
  } seqStateT;

  ////////////////////////////////////////////////////////////////////////////
  // Control strobes from the decoder to the datapath
  typedef struct packed {
    logic pcInc;       // Step PC
    logic abusToPc;    // Jump target from address bus
    logic dbusToPc;    // POPPC target from data bus
    logic dbusToIr;
    logic dbusToTop;
    logic dbusToRam;
    logic dbusToPort;
    logic push;
    logic pop;
    // Address bus sources in priority order
    logic pcToAbus;
    logic irToAbus;
    logic nextToAbus;
    logic topToAbus;
    // Data bus sources in priority order
    logic irToDbus;
    logic topToDbus;
    logic aluToDbus;
    logic ramToDbus;
    logic inToDbus;
    logic pcToDbus;
  } ctrlT;

endpackage

// File: cpuControl.sv
// Sequencer and decoder of the stack CPU. HALT and unused opcodes execute as no-ops, every instruction takes 3 or 4 cycles.
`timescale 1ns/10ps

module cpuControl (
  input  logic          clk,
  input  logic          reset,
  input  corePkg::wordT dataBus,
  input  corePkg::wordT stackTop,
  output corePkg::ctrlT ctrl,
  output corePkg::wordT instr
);

  corePkg::seqStateT state;
  isaPkg::opcodeT    opcode;
  isaPkg::aluFuncT   func;
  logic              needExecB;

  assign opcode    = isaPkg::opcodeT'(instr[isaPkg::OpcodeHi:isaPkg::OpcodeLo]);
  assign func      = isaPkg::aluFuncT'(instr[isaPkg::FuncHi:isaPkg::FuncLo]);
  assign needExecB = (opcode == isaPkg::opPush) || (opcode == isaPkg::opLd) ||
                     (opcode == isaPkg::opSt);  // Second RAM cycle or second pop

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  always_ff @(posedge clk)
  begin
    if (!reset)
      state <= corePkg::idle;
    else
    begin
      case (state)
        corePkg::idle:   state <= corePkg::fetchA;
        corePkg::fetchA: state <= corePkg::fetchB;
        corePkg::fetchB: state <= corePkg::execA;
        corePkg::execA:  state <= needExecB ? corePkg::execB : corePkg::fetchA;
        default:         state <= corePkg::fetchA;  // execB and stray codes
      endcase
    end
  end

  // Instruction register, loaded from RAM data in fetchB
  always_ff @(posedge clk)
  begin
    if (!reset)
      instr <= '0;
    else if (ctrl.dbusToIr)
      instr <= dataBus;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  always_comb
  begin
    ctrl = '0;
    case (state)
      corePkg::fetchA:
      begin
        ctrl.pcToAbus = 1'b1;  // Address the next word
        ctrl.pcInc    = 1'b1;
      end
      corePkg::fetchB:
      begin
        ctrl.pcToAbus  = 1'b1;
        ctrl.ramToDbus = 1'b1;  // Read data arrives now
        ctrl.dbusToIr  = 1'b1;
      end
      corePkg::execA:
      begin
        case (opcode)
          isaPkg::opPushi:
          begin
            ctrl.irToDbus  = 1'b1;
            ctrl.dbusToTop = 1'b1;
            ctrl.push      = 1'b1;
          end
          isaPkg::opPush: ctrl.irToAbus = 1'b1;  // Read, push in execB
          isaPkg::opPop:
          begin
            ctrl.irToAbus  = 1'b1;
            ctrl.topToDbus = 1'b1;
            ctrl.dbusToRam = 1'b1;
            ctrl.pop       = 1'b1;
          end
          isaPkg::opJmp:
          begin
            ctrl.irToAbus = 1'b1;
            ctrl.abusToPc = 1'b1;
          end
          isaPkg::opJz, isaPkg::opJnz:
          begin
            // Jump when top matches the condition, pop either way
            if ((stackTop == '0) == (opcode == isaPkg::opJz))
            begin
              ctrl.irToAbus = 1'b1;
              ctrl.abusToPc = 1'b1;
            end
            ctrl.pop = 1'b1;
          end
          isaPkg::opLd: ctrl.topToAbus = 1'b1;  // Top is the address
          isaPkg::opSt:
          begin
            ctrl.nextToAbus = 1'b1;  // Store top at address in next
            ctrl.topToDbus  = 1'b1;
            ctrl.dbusToRam  = 1'b1;
            ctrl.pop        = 1'b1;  // First of two pops
          end
          isaPkg::opPppc:
          begin
            if (!instr[0])  // PUSHPC
            begin
              ctrl.pcToDbus  = 1'b1;
              ctrl.dbusToTop = 1'b1;
              ctrl.push      = 1'b1;
            end
            else  // POPPC
            begin
              ctrl.topToDbus = 1'b1;
              ctrl.dbusToPc  = 1'b1;
              ctrl.pop       = 1'b1;
            end
          end
          isaPkg::opIn:
          begin
            ctrl.inToDbus  = 1'b1;
            ctrl.dbusToTop = 1'b1;
            ctrl.push      = 1'b1;
          end
          isaPkg::opOut:
          begin
            ctrl.topToDbus  = 1'b1;
            ctrl.dbusToPort = 1'b1;
            ctrl.pop        = 1'b1;
          end
          isaPkg::opOp:
          begin
            ctrl.aluToDbus = 1'b1;
            ctrl.dbusToTop = 1'b1;
            ctrl.pop       = !func[4];  // Binary ops consume next
            case (func)
              isaPkg::funcA, isaPkg::funcBa: ctrl.push = 1'b1;  // Dup, over
              isaPkg::funcB, isaPkg::funcAa: ctrl.pop  = 1'b1;  // Drop, dropnext
              default: ;
            endcase
          end
          default: ;  // HALT
        endcase
      end
      corePkg::execB:
      begin
        case (opcode)
          isaPkg::opPush:
          begin
            ctrl.ramToDbus = 1'b1;
            ctrl.dbusToTop = 1'b1;
            ctrl.push      = 1'b1;
          end
          isaPkg::opLd:
          begin
            ctrl.ramToDbus = 1'b1;  // Replace address with data
            ctrl.dbusToTop = 1'b1;
          end
          isaPkg::opSt: ctrl.pop = 1'b1;  // Drop the address
          default: ;
        endcase
      end
      default: ;  // Idle drives nothing
    endcase
  end

endmodule

// File: programCounter.sv
// Instruction address counter. Wraps from the top address to zero.
`timescale 1ns/10ps

module programCounter (
  input  logic          clk,
  input  logic          reset,
  input  logic          load,
  input  logic          inc,
  input  corePkg::addrT nextAddr,
  output corePkg::addrT pc
);

  always_ff @(posedge clk)
  begin
    if (!reset)
      pc <= '0;
    else if (load)  // Jump wins over step
      pc <= nextAddr;
    else if (inc)
      pc <= pc + corePkg::addrT'(1);
  end

endmodule

// File: operandStack.sv
// Shift-register operand stack with no depth check. StackDepth must be at least 3; overflow loses the bottom entry.
`timescale 1ns/10ps

module operandStack #(
  parameter int StackDepth = 8
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          load,
  input  logic          push,
  input  logic          pop,
  input  corePkg::wordT dataIn,
  output corePkg::wordT top,
  output corePkg::wordT next
);

  corePkg::wordT entry [StackDepth];

  assign top  = entry[0];
  assign next = entry[1];

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      for (int i = 0; i < StackDepth; i++)
      begin
        entry[i] <= '0;
      end
    end
    else
    begin
      if (load)
        entry[0] <= dataIn;  // New top, also on push
      else if (pop)
        entry[0] <= entry[1];
      for (int i = 1; i < StackDepth - 1; i++)
      begin
        if (push)
          entry[i] <= entry[i-1];
        else if (pop)
          entry[i] <= entry[i+1];
      end
      if (push)
        entry[StackDepth-1] <= entry[StackDepth-2];  // Bottom holds on pop
    end
  end

endmodule

// File: stackAlu.sv
// ALU over the top two stack entries, next is the left operand. Ordered compares are signed, unlisted codes give zero.
`timescale 1ns/10ps

module stackAlu (
  input  corePkg::wordT   top,
  input  corePkg::wordT   next,
  input  isaPkg::aluFuncT func,
  output corePkg::wordT   result
);

  corePkg::wordT topBiased;
  corePkg::wordT nextBiased;

  // Offset by 2^17 so unsigned compares order signed values
  assign topBiased  = top + corePkg::wordT'(18'h20000);
  assign nextBiased = next + corePkg::wordT'(18'h20000);

  always_comb
  begin
    case (func)
      isaPkg::funcAdd:  result = next + top;
      isaPkg::funcSub:  result = next - top;
      isaPkg::funcMul:  result = next * top;  // Low 18 bits kept
      isaPkg::funcShl:  result = next << top;
      isaPkg::funcShr:  result = next >> top;  // Logical shift
      isaPkg::funcBand: result = next & top;
      isaPkg::funcBor:  result = next | top;
      isaPkg::funcBxor: result = next ^ top;
      // Truth values as 1 or 0
      isaPkg::funcAnd:  result = corePkg::wordT'((next != '0) && (top != '0));
      isaPkg::funcOr:   result = corePkg::wordT'((next != '0) || (top != '0));
      isaPkg::funcEq:   result = corePkg::wordT'(next == top);
      isaPkg::funcNe:   result = corePkg::wordT'(next != top);
      isaPkg::funcGe:   result = corePkg::wordT'(nextBiased >= topBiased);
      isaPkg::funcLe:   result = corePkg::wordT'(nextBiased <= topBiased);
      isaPkg::funcGt:   result = corePkg::wordT'(nextBiased > topBiased);
      isaPkg::funcLt:   result = corePkg::wordT'(nextBiased < topBiased);
      // Unary on top
      isaPkg::funcNeg:  result = -top;
      isaPkg::funcBnot: result = ~top;
      isaPkg::funcNot:  result = corePkg::wordT'(top == '0);
      isaPkg::funcA,
      isaPkg::funcAa:   result = top;  // Dup, dropnext
      isaPkg::funcB,
      isaPkg::funcBa:   result = next;  // Drop, over
      default:          result = '0;
    endcase
  end

endmodule

// File: programRam.sv
// Single-port RAM for program and data, contents not cleared by reset. RamWords must not exceed 4096.
`timescale 1ns/10ps

module programRam #(
  parameter int RamWords = 4096
) (
  input  logic          clk,
  input  logic          write,
  input  corePkg::addrT addr,
  input  corePkg::wordT dataIn,
  output corePkg::wordT dataOut
);

  corePkg::wordT mem [RamWords];

  always_ff @(posedge clk)
  begin
    if (write)
      mem[addr] <= dataIn;
    dataOut <= mem[addr];  // Old contents on a write cycle
  end

endmodule

// File: ioPorts.sv
// Four output registers and four inputs with no handshake. Port numbers 4 to 7 read zero and ignore writes.
`timescale 1ns/10ps

module ioPorts (
  input  logic            clk,
  input  logic            reset,
  input  logic            write,
  input  isaPkg::portSelT portSel,
  input  corePkg::wordT   dataIn,
  input  corePkg::wordT   inPort0,
  input  corePkg::wordT   inPort1,
  input  corePkg::wordT   inPort2,
  input  corePkg::wordT   inPort3,
  output corePkg::wordT   inValue,
  output corePkg::wordT   outPort0,
  output corePkg::wordT   outPort1,
  output corePkg::wordT   outPort2,
  output corePkg::wordT   outPort3
);

  corePkg::wordT outReg [4];

  assign outPort0 = outReg[0];
  assign outPort1 = outReg[1];
  assign outPort2 = outReg[2];
  assign outPort3 = outReg[3];

  always_ff @(posedge clk)
  begin
    if (!reset)
      outReg <= '{default: '0};
    else if (write && !portSel[2])  // Upper four ports not wired
      outReg[portSel[1:0]] <= dataIn;
  end

  // Input select for IN
  always_comb
  begin
    case (portSel)
      3'd0:    inValue = inPort0;
      3'd1:    inValue = inPort1;
      3'd2:    inValue = inPort2;
      3'd3:    inValue = inPort3;
      default: inValue = '0;
    endcase
  end

endmodule

// File: stackCpu.sv
// Stack CPU top level. The program is written through the load port only while reset is low.
`timescale 1ns/10ps

module stackCpu #(
  parameter int StackDepth = 8,
  parameter int RamWords   = 4096
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          loadEnable,
  input  corePkg::addrT loadAddr,
  input  corePkg::wordT loadData,
  input  corePkg::wordT inPort0,
  input  corePkg::wordT inPort1,
  input  corePkg::wordT inPort2,
  input  corePkg::wordT inPort3,
  output corePkg::wordT outPort0,
  output corePkg::wordT outPort1,
  output corePkg::wordT outPort2,
  output corePkg::wordT outPort3
);

  corePkg::ctrlT ctrl;
  corePkg::wordT instr, top, next, aluOut, ramOut, inValue;
  corePkg::wordT dataBus, immExt, ramDataIn;
  corePkg::addrT addrBus, pc, pcNext, ramAddr;
  logic          ramWrite;

  // 12-bit immediate sign-extended to a word
  assign immExt = {{($bits(corePkg::wordT) - isaPkg::ImmHi - 1){instr[isaPkg::ImmHi]}},
                   instr[isaPkg::ImmHi:isaPkg::ImmLo]};

  ////////////////////////////////////////////////////////////////////////////
  // Buses, first active source wins
  always_comb
  begin
    if (ctrl.pcToAbus)        addrBus = pc;
    else if (ctrl.irToAbus)   addrBus = instr[isaPkg::ImmHi:isaPkg::ImmLo];
    else if (ctrl.nextToAbus) addrBus = next[$bits(corePkg::addrT)-1:0];  // ST
    else if (ctrl.topToAbus)  addrBus = top[$bits(corePkg::addrT)-1:0];  // LD
    else                      addrBus = '0;
  end

  always_comb
  begin
    if (ctrl.irToDbus)       dataBus = immExt;
    else if (ctrl.topToDbus) dataBus = top;
    else if (ctrl.aluToDbus) dataBus = aluOut;
    else if (ctrl.ramToDbus) dataBus = ramOut;
    else if (ctrl.inToDbus)  dataBus = inValue;
    else if (ctrl.pcToDbus)  dataBus = corePkg::wordT'(pc);  // PUSHPC
    else                     dataBus = '0;
  end

  assign pcNext = ctrl.dbusToPc ? dataBus[$bits(corePkg::addrT)-1:0] : addrBus;

  // Load port owns the RAM while reset is low
  assign ramWrite  = reset ? ctrl.dbusToRam : loadEnable;
  assign ramAddr   = reset ? addrBus : loadAddr;
  assign ramDataIn = reset ? dataBus : loadData;

  ////////////////////////////////////////////////////////////////////////////
  cpuControl control (.clk, .reset, .dataBus, .stackTop(top), .ctrl, .instr);

  programCounter pcReg (.clk, .reset, .load(ctrl.abusToPc | ctrl.dbusToPc),
                        .inc(ctrl.pcInc), .nextAddr(pcNext), .pc);

  operandStack #(.StackDepth(StackDepth)) stack (.clk, .reset, .load(ctrl.dbusToTop),
    .push(ctrl.push), .pop(ctrl.pop), .dataIn(dataBus), .top, .next);

  stackAlu alu (.top, .next, .result(aluOut),
                .func(isaPkg::aluFuncT'(instr[isaPkg::FuncHi:isaPkg::FuncLo])));

  programRam #(.RamWords(RamWords)) ram (.clk, .write(ramWrite), .addr(ramAddr),
                                         .dataIn(ramDataIn), .dataOut(ramOut));

  ioPorts ports (.clk, .reset, .write(ctrl.dbusToPort), .dataIn(dataBus),
    .portSel(isaPkg::portSelT'(instr[isaPkg::PortHi:isaPkg::PortLo])),
    .inPort0, .inPort1, .inPort2, .inPort3, .inValue,
    .outPort0, .outPort1, .outPort2, .outPort3);

endmodule

// File: stackCpu_props.sv
// Sequencer and port write checks for every cpuControl instance. Reset low disables them.
`timescale 1ns/10ps

module stackCpuProps (
  input logic              clk,
  input logic              reset,
  input corePkg::seqStateT state,
  input isaPkg::opcodeT    opcode,
  input corePkg::ctrlT     ctrl,
  input corePkg::wordT     dataBus,
  input corePkg::wordT     stackTop
);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  stateLegal: assert property (@(posedge clk) disable iff (!reset)
    state inside {corePkg::idle, corePkg::fetchA, corePkg::fetchB,
                  corePkg::execA, corePkg::execB})
    else $error("Sequencer state outside its five codes");

  // Second exec cycle only for RAM reads and ST
  execBSource: assert property (@(posedge clk) disable iff (!reset)
    (state == corePkg::execB) |->
      ($past(state) == corePkg::execA) &&
      ($past(opcode) inside {isaPkg::opPush, isaPkg::opLd, isaPkg::opSt}))
    else $error("execB reached from an opcode without a second cycle");

  idleQuiet: assert property (@(posedge clk) disable iff (!reset)
    (state == corePkg::idle) |-> (ctrl == '0))
    else $error("Control strobe active while idle");

  // Port writes carry the stack top
  portData: assert property (@(posedge clk) disable iff (!reset)
    ctrl.dbusToPort |-> (dataBus == stackTop))
    else $error("Port write data differs from the stack top");

endmodule

bind cpuControl stackCpuProps seqChecks (
  .clk(clk),
  .reset(reset),
  .state(state),
  .opcode(opcode),
  .ctrl(ctrl),
  .dataBus(dataBus),
  .stackTop(stackTop)
);

// File: stackCpuTb.sv
// Table-driven regression for stackCpu. Programs hold at most 16 words and end by writing 1 to port 1.
`timescale 1ns/10ps

module stackCpuTb;

  localparam int ProgWords = 16;
  localparam int WaitLimit = 400;  // Cycles allowed per program

  // One table row
  typedef struct packed {
    corePkg::wordT [ProgWords-1:0] prog;      // RAM image from address 0
    corePkg::wordT                 in0;
    corePkg::wordT                 in1;
    corePkg::wordT                 expected;  // outPort0 at completion
  } entryT;

  logic          clk;
  logic          reset;
  logic          loadEnable;
  corePkg::addrT loadAddr;
  corePkg::wordT loadData;
  corePkg::wordT inPort0, inPort1, inPort2, inPort3;
  corePkg::wordT outPort0, outPort1, outPort2, outPort3;

  entryT tests[$];
  entryT cur;          // Row under construction
  int    fill;         // Next free program slot
  int    checkErrors;
  int    timeouts;

  stackCpu #(.StackDepth(8), .RamWords(4096)) uut (
    .clk, .reset, .loadEnable, .loadAddr, .loadData,
    .inPort0, .inPort1, .inPort2, .inPort3,
    .outPort0, .outPort1, .outPort2, .outPort3
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules

  // 12-bit immediate to an 18-bit word
  function automatic corePkg::wordT signExtend(logic [11:0] imm);
    return {{6{imm[11]}}, imm};
  endfunction

  // Expected ALU result, a is next and b is top
  function automatic corePkg::wordT aluModel(isaPkg::aluFuncT f, corePkg::wordT a,
                                             corePkg::wordT b);
    logic [35:0] prod;
    prod = {18'b0, a} * {18'b0, b};
    case (f)
      isaPkg::funcAdd:  return a + b;
      isaPkg::funcSub:  return a - b;
      isaPkg::funcMul:  return prod[17:0];  // Modulo 2^18
      isaPkg::funcShl:  return (b >= 18'd18) ? '0 : a << b;
      isaPkg::funcShr:  return (b >= 18'd18) ? '0 : a >> b;
      isaPkg::funcBand: return a & b;
      isaPkg::funcBor:  return a | b;
      isaPkg::funcBxor: return a ^ b;
      isaPkg::funcAnd:  return corePkg::wordT'((a != '0) && (b != '0));
      isaPkg::funcOr:   return corePkg::wordT'((a != '0) || (b != '0));
      isaPkg::funcEq:   return corePkg::wordT'(a == b);
      isaPkg::funcNe:   return corePkg::wordT'(a != b);
      isaPkg::funcGe:   return corePkg::wordT'($signed(a) >= $signed(b));
      isaPkg::funcLe:   return corePkg::wordT'($signed(a) <= $signed(b));
      isaPkg::funcGt:   return corePkg::wordT'($signed(a) > $signed(b));
      isaPkg::funcLt:   return corePkg::wordT'($signed(a) < $signed(b));
      isaPkg::funcNeg:  return -b;
      isaPkg::funcBnot: return ~b;
      isaPkg::funcNot:  return corePkg::wordT'(b == '0);
      isaPkg::funcA,
      isaPkg::funcAa:   return b;  // Dup, dropnext keep top
      isaPkg::funcB,
      isaPkg::funcBa:   return a;  // Drop, over surface next
      default:          return '0;
    endcase
  endfunction

  function automatic corePkg::wordT portValue(int p);
    case (p)
      0:       return outPort0;
      1:       return outPort1;
      2:       return outPort2;
      default: return outPort3;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Table construction

  task automatic nextCycle();
    @(posedge clk);
    #1;  // Drive and sample clear of the edge
  endtask

  task automatic startEntry(corePkg::wordT in0, corePkg::wordT in1);
    cur     = '0;  // Unused slots are HALT
    cur.in0 = in0;
    cur.in1 = in1;
    fill    = 0;
  endtask

  task automatic emit(isaPkg::opcodeT op, logic [11:0] field);
    cur.prog[4'(fill)] = {2'b00, op, field};
    fill++;
  endtask

  task automatic aluOp(isaPkg::aluFuncT f);
    emit(isaPkg::opOp, {7'b0, f});
  endtask

  // Completion flag on port 1, then park
  task automatic closeEntry(corePkg::wordT expected);
    emit(isaPkg::opPushi, 12'd1);
    emit(isaPkg::opOut, 12'd1);
    emit(isaPkg::opJmp, 12'(fill));  // Jump to itself
    cur.expected = expected;
    tests.push_back(cur);
  endtask

  task automatic buildTests();
    isaPkg::aluFuncT f;
    isaPkg::aluFuncT eqFuncs [3] = '{isaPkg::funcEq, isaPkg::funcGe, isaPkg::funcLe};
    logic [11:0]     a;
    logic [11:0]     b;
    corePkg::wordT   x;
    corePkg::wordT   y;
    bit              taken;

    // Every ALU code on random immediates
    f = f.first();
    for (int k = 0; k < f.num(); k++)
    begin
      a = 12'($urandom);
      if (f == isaPkg::funcShl || f == isaPkg::funcShr)
        b = 12'($urandom % 20);  // Counts mostly under 18
      else
        b = 12'($urandom);
      startEntry('0, '0);
      emit(isaPkg::opPushi, a);
      emit(isaPkg::opPushi, b);
      aluOp(f);
      emit(isaPkg::opOut, 12'd0);
      closeEntry(aluModel(f, signExtend(a), signExtend(b)));
      f = f.next();
    end
    for (int k = 0; k < 3; k++)  // Equal operands
    begin
      a = 12'($urandom);
      startEntry('0, '0);
      emit(isaPkg::opPushi, a);
      emit(isaPkg::opPushi, a);
      aluOp(eqFuncs[k]);
      emit(isaPkg::opOut, 12'd0);
      closeEntry(aluModel(eqFuncs[k], signExtend(a), signExtend(a)));
    end

    // RAM round trips, POP/PUSH then ST/LD
    a = 12'($urandom);
    startEntry('0, '0);
    emit(isaPkg::opPushi, a);
    emit(isaPkg::opPop, 12'h100);
    emit(isaPkg::opPush, 12'h100);
    emit(isaPkg::opOut, 12'd0);
    closeEntry(signExtend(a));
    a = 12'($urandom);
    startEntry('0, '0);
    emit(isaPkg::opPushi, 12'h101);  // Address below value
    emit(isaPkg::opPushi, a);
    emit(isaPkg::opSt, 12'd0);
    emit(isaPkg::opPushi, 12'h101);
    emit(isaPkg::opLd, 12'd0);
    emit(isaPkg::opOut, 12'd0);
    closeEntry(signExtend(a));

    // JZ and JNZ over a PUSHI
    for (int useNz = 0; useNz < 2; useNz++)
    begin
      for (int cond = 0; cond < 2; cond++)
      begin
        startEntry('0, '0);
        emit(isaPkg::opPushi, 12'h022);
        emit(isaPkg::opPushi, (cond != 0) ? 12'h005 : 12'h000);  // Tested top
        if (useNz != 0)
          emit(isaPkg::opJnz, 12'd4);
        else
          emit(isaPkg::opJz, 12'd4);
        emit(isaPkg::opPushi, 12'h033);  // Skipped when taken
        emit(isaPkg::opOut, 12'd0);
        taken = (useNz != 0) ? (cond != 0) : (cond == 0);
        closeEntry(taken ? 18'h00022 : 18'h00033);
      end
    end

    // Call and return through PUSHPC and POPPC
    startEntry('0, '0);
    emit(isaPkg::opJmp, 12'd2);
    emit(isaPkg::opPppc, 12'd1);    // Subroutine is a bare POPPC
    emit(isaPkg::opPushi, 12'h040);
    emit(isaPkg::opPppc, 12'd0);    // Pushes 4
    emit(isaPkg::opPushi, 12'd5);
    aluOp(isaPkg::funcAdd);         // Return address 9
    emit(isaPkg::opJmp, 12'd1);
    emit(isaPkg::opPushi, 12'd1);   // Wrong path marker
    aluOp(isaPkg::funcAdd);
    emit(isaPkg::opPushi, 12'd2);
    aluOp(isaPkg::funcAdd);
    emit(isaPkg::opOut, 12'd0);
    closeEntry(18'h00042);

    // IN adds both ports, first case wraps
    for (int k = 0; k < 3; k++)
    begin
      x = (k == 0) ? 18'h3FFFF : 18'($urandom);
      y = (k == 0) ? 18'h00002 : 18'($urandom);
      startEntry(x, y);
      emit(isaPkg::opIn, 12'd0);
      emit(isaPkg::opIn, 12'd1);
      aluOp(isaPkg::funcAdd);
      emit(isaPkg::opOut, 12'd0);
      closeEntry(x + y);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stack shuffles
    startEntry('0, '0);
    emit(isaPkg::opPushi, 12'd3);
    aluOp(isaPkg::funcA);    // 3 3
    aluOp(isaPkg::funcMul);
    emit(isaPkg::opOut, 12'd0);
    closeEntry(18'd9);
    startEntry('0, '0);
    emit(isaPkg::opPushi, 12'd5);
    emit(isaPkg::opPushi, 12'd7);
    aluOp(isaPkg::funcBa);   // 5 7 5
    aluOp(isaPkg::funcSub);  // 7 minus 5
    emit(isaPkg::opOut, 12'd0);
    closeEntry(18'd2);
    startEntry('0, '0);
    emit(isaPkg::opPushi, 12'd4);
    emit(isaPkg::opPushi, 12'd6);
    emit(isaPkg::opPushi, 12'd9);
    aluOp(isaPkg::funcB);    // 4 6
    aluOp(isaPkg::funcAdd);
    emit(isaPkg::opOut, 12'd0);
    closeEntry(18'd10);
    startEntry('0, '0);
    emit(isaPkg::opPushi, 12'd1);
    emit(isaPkg::opPushi, 12'd2);
    emit(isaPkg::opPushi, 12'd3);
    aluOp(isaPkg::funcAa);   // 1 3
    aluOp(isaPkg::funcSub);
    emit(isaPkg::opOut, 12'd0);
    closeEntry(18'h3FFFE);   // 1 minus 3
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Apply one row

  task automatic runEntry(entryT e, int idx);
    int cycles;
    nextCycle();
    reset   = 1'b0;
    inPort0 = e.in0;
    inPort1 = e.in1;
    repeat (10) nextCycle();
    for (int i = 0; i < ProgWords; i++)  // Load port owns the RAM in reset
    begin
      loadEnable = 1'b1;
      loadAddr   = corePkg::addrT'(i);
      loadData   = e.prog[4'(i)];
      nextCycle();
    end
    loadEnable = 1'b0;
    reset      = 1'b1;
    nextCycle();  // Idle to fetchA, no OUT yet
    for (int p = 0; p < 4; p++)
    begin
      assert (portValue(p) == '0)
      else
      begin
        checkErrors++;
        $display("CHECK FAILED entry %0d outPort%0d after reset: got %h expected %h",
                 idx, p, portValue(p), 18'h0);
      end
    end
    cycles = 0;
    while (outPort1 != 18'd1 && cycles < WaitLimit)
    begin
      nextCycle();
      cycles++;
    end
    assert (outPort1 == 18'd1)
    else
    begin
      timeouts++;
      $display("Entry %0d never set outPort1 to 1 within %0d cycles", idx, WaitLimit);
    end
    if (outPort1 == 18'd1)
    begin
      assert (outPort0 == e.expected)
      else
      begin
        checkErrors++;
        $display("CHECK FAILED entry %0d outPort0: got %h expected %h",
                 idx, outPort0, e.expected);
      end
    end
  endtask

  initial
  begin
    void'($urandom(48));  // Fixed seed
    reset       = 1'b0;
    loadEnable  = 1'b0;
    loadAddr    = '0;
    loadData    = '0;
    inPort0     = '0;
    inPort1     = '0;
    inPort2     = '0;
    inPort3     = '0;
    checkErrors = 0;
    timeouts    = 0;
    buildTests();
    foreach (tests[t])
      runEntry(tests[t], t);
    $display("Ran %0d programs with %0d check errors and %0d timeouts",
             tests.size(), checkErrors, timeouts);
    if (checkErrors == 0 && timeouts == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// File: vlog.f
isaPkg.sv
corePkg.sv
cpuControl.sv
programCounter.sv
operandStack.sv
stackAlu.sv
programRam.sv
ioPorts.sv
stackCpu.sv
stackCpu_props.sv
stackCpuTb.sv

// File: Makefile
# Verilator build and run of the stack CPU regression

VERILATOR ?= verilator
TOP       ?= stackCpuTb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASSTEXT  ?= Regression passed

.PHONY: sim clean

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASSTEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
